//--- rtl/fpu_pkg.sv
////////////////////////////////////////////////////////////
// fpu side unit shared types
////////////////////////////////////////////////////////////

package fpu_pkg;

  // two single-precision lanes per operand
  localparam int DATA_W   = 64;
  localparam int SGL_W    = 32;
  // result bus adds even parity as the top bit
  localparam int RESULT_W = DATA_W + 1;

  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [RESULT_W-1:0] result_t;

  typedef enum logic [2:0] {
    OP_NOP     = 3'd0,
    OP_COPY_A  = 3'd1,
    OP_COPY_B  = 3'd2,
    OP_SWAP    = 3'd3,
    OP_DUP_LO  = 3'd4,
    OP_CMP_S   = 3'd5,
    OP_CMPU_S  = 3'd6,
    OP_PCMP_LT = 3'd7
  } fpu_op_e;

  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic unord;
  } cmp_flags_t;

  typedef enum logic [1:0] {
    EXC_NONE     = 2'd0,
    EXC_INVALID  = 2'd1,
    EXC_DENORMAL = 2'd2
  } exc_code_e;

endpackage

//--- rtl/exec_if.sv
////////////////////////////////////////////////////////////
// issue stage to execution lanes
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface exec_if;
  import fpu_pkg::*;

  // high for one cycle per issued op
  logic    valid;
  fpu_op_e op;
  data_t   a;
  data_t   b;

  modport issue (
    output valid, op, a, b
  );

  modport exec (
    input valid, op, a, b
  );

endinterface

//--- rtl/operand_forward.sv
////////////////////////////////////////////////////////////
// operand forwarding from result buses
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module operand_forward #(
  parameter int NUM_BUS = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  fpu_pkg::data_t       reg_val,
  input  logic [NUM_BUS-1:0]   fwd_now,
  input  logic [NUM_BUS-1:0]   fwd_old,
  input  fpu_pkg::result_t     buses [NUM_BUS],
  output fpu_pkg::data_t       operand
);
  import fpu_pkg::*;

  // bus data one cycle back, parity dropped
  data_t bus_old [NUM_BUS];

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_BUS; i++) begin
      if (rst) begin
        bus_old[i] <= '0;
      end else begin
        bus_old[i] <= buses[i][DATA_W-1:0];
      end
    end
  end

  // live bus wins over the older copy, register value last
  always_comb begin
    operand = reg_val;
    for (int i = 0; i < NUM_BUS; i++) begin
      if (fwd_old[i]) begin
        operand = bus_old[i];
      end
    end
    for (int i = 0; i < NUM_BUS; i++) begin
      if (fwd_now[i]) begin
        operand = buses[i][DATA_W-1:0];
      end
    end
  end

endmodule

//--- rtl/fpu_issue.sv
////////////////////////////////////////////////////////////
// opcode decode and issue register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpu_issue (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  fpu_pkg::fpu_op_e op,
  input  fpu_pkg::data_t   a,
  input  fpu_pkg::data_t   b,
  exec_if.issue            issue
);
  import fpu_pkg::*;

  logic take;

  // nop never occupies the pipe
  assign take = en && (op != OP_NOP);

  // control part of the issue stage
  always_ff @(posedge clk) begin
    if (rst) begin
      issue.valid <= 1'b0;
      issue.op    <= OP_NOP;
    end else begin
      issue.valid <= take;
      if (take) begin
        issue.op <= op;
      end
    end
  end

  // forwarded operands, held until the next issue
  always_ff @(posedge clk) begin
    if (take) begin
      issue.a <= a;
      issue.b <= b;
    end
  end

endmodule

//--- rtl/fpu_compare.sv
////////////////////////////////////////////////////////////
// single-precision compare, scalar and packed
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpu_compare (
  exec_if.exec                 issue,
  output fpu_pkg::cmp_flags_t  flags,
  output fpu_pkg::data_t       mask,
  output logic [1:0]           raise
);
  import fpu_pkg::*;

  cmp_flags_t lo_f;
  cmp_flags_t hi_f;
  logic [SGL_W-1:0] a_lo;
  logic [SGL_W-1:0] a_hi;
  logic [SGL_W-1:0] b_lo;
  logic [SGL_W-1:0] b_hi;
  logic nan_lo;
  logic nan_hi;
  logic den_lo;
  logic den_hi;
  logic is_scalar;
  logic is_packed;

  function automatic logic is_nan(input logic [SGL_W-1:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != '0);
  endfunction

  function automatic logic is_zero(input logic [SGL_W-1:0] x);
    return (x[30:23] == 8'h00) && (x[22:0] == '0);
  endfunction

  function automatic logic is_denorm(input logic [SGL_W-1:0] x);
    return (x[30:23] == 8'h00) && (x[22:0] != '0);
  endfunction

  // sign-magnitude order, +0 and -0 are equal
  function automatic cmp_flags_t cmp_lane(input logic [SGL_W-1:0] x,
                                          input logic [SGL_W-1:0] y);
    cmp_flags_t f;
    logic x_lt_y;
    f = '0;
    x_lt_y = 1'b0;
    if (is_nan(x) || is_nan(y)) begin
      f.unord = 1'b1;
    end else if ((is_zero(x) && is_zero(y)) || (x == y)) begin
      f.eq = 1'b1;
    end else begin
      if (x[SGL_W-1] != y[SGL_W-1]) begin
        x_lt_y = x[SGL_W-1];
      end else if (x[SGL_W-1]) begin
        // both negative, larger magnitude is smaller
        x_lt_y = x[SGL_W-2:0] > y[SGL_W-2:0];
      end else begin
        x_lt_y = x[SGL_W-2:0] < y[SGL_W-2:0];
      end
      f.lt = x_lt_y;
      f.gt = !x_lt_y;
    end
    return f;
  endfunction

  assign a_lo = issue.a[SGL_W-1:0];
  assign a_hi = issue.a[DATA_W-1:SGL_W];
  assign b_lo = issue.b[SGL_W-1:0];
  assign b_hi = issue.b[DATA_W-1:SGL_W];

  assign lo_f = cmp_lane(a_lo, b_lo);
  assign hi_f = cmp_lane(a_hi, b_hi);

  // scalar flags come from the low lane
  assign flags = lo_f;
  assign mask  = {{SGL_W{hi_f.lt}}, {SGL_W{lo_f.lt}}};

  assign nan_lo = is_nan(a_lo) || is_nan(b_lo);
  assign nan_hi = is_nan(a_hi) || is_nan(b_hi);
  assign den_lo = is_denorm(a_lo) || is_denorm(b_lo);
  assign den_hi = is_denorm(a_hi) || is_denorm(b_hi);

  assign is_scalar = (issue.op == OP_CMP_S) || (issue.op == OP_CMPU_S);
  assign is_packed = (issue.op == OP_PCMP_LT);

  // bit 0 invalid, bit 1 denormal; unordered compare is quiet
  assign raise[0] = issue.valid &&
                    (((issue.op == OP_CMP_S) && nan_lo) ||
                     (is_packed && (nan_lo || nan_hi)));
  assign raise[1] = issue.valid &&
                    ((is_scalar && den_lo) ||
                     (is_packed && (den_lo || den_hi)));

endmodule

//--- rtl/fpu_result.sv
////////////////////////////////////////////////////////////
// permute lane and result bus register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpu_result (
  input  logic                 clk,
  input  logic                 rst,
  exec_if.exec                 issue,
  input  fpu_pkg::cmp_flags_t  cmp_flags,
  input  fpu_pkg::data_t       cmp_mask,
  input  fpu_pkg::cmp_flags_t  flags_in,
  output logic                 res_valid,
  output fpu_pkg::result_t     res,
  output fpu_pkg::cmp_flags_t  flags_out
);
  import fpu_pkg::*;

  data_t res_data;
  logic  is_scalar;

  assign is_scalar = (issue.op == OP_CMP_S) || (issue.op == OP_CMPU_S);

  // lane arrangement per opcode, scalar compares give zero data
  always_comb begin
    case (issue.op)
      OP_COPY_A:  res_data = issue.a;
      OP_COPY_B:  res_data = issue.b;
      OP_SWAP:    res_data = {issue.a[SGL_W-1:0], issue.a[DATA_W-1:SGL_W]};
      OP_DUP_LO:  res_data = {issue.a[SGL_W-1:0], issue.a[SGL_W-1:0]};
      OP_PCMP_LT: res_data = cmp_mask;
      default:    res_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      flags_out <= '0;
    end else begin
      res_valid <= issue.valid;
      if (issue.valid) begin
        // non-compare ops pass the incoming flags through
        flags_out <= is_scalar ? cmp_flags : flags_in;
      end
    end
  end

  // even parity on top of the data
  always_ff @(posedge clk) begin
    if (issue.valid) begin
      res <= {^res_data, res_data};
    end
  end

endmodule

//--- rtl/fpu_except.sv
////////////////////////////////////////////////////////////
// masked exception report
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpu_except (
  input  logic                clk,
  input  logic                rst,
  input  logic [1:0]          raise,
  input  logic [1:0]          exc_enable,
  output logic                exc_valid,
  output fpu_pkg::exc_code_e  exc_code
);
  import fpu_pkg::*;

  logic [1:0] raise_q;
  logic [1:0] hit;
  exc_code_e  code_nxt;

  assign hit = raise_q & exc_enable;

  // invalid beats denormal
  always_comb begin
    if (hit[0]) begin
      code_nxt = EXC_INVALID;
    end else if (hit[1]) begin
      code_nxt = EXC_DENORMAL;
    end else begin
      code_nxt = EXC_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      raise_q   <= 2'b00;
      exc_valid <= 1'b0;
      exc_code  <= EXC_NONE;
    end else begin
      raise_q   <= raise;
      exc_valid <= |hit;
      exc_code  <= code_nxt;
    end
  end

endmodule

//--- rtl/fpu_unit_top.sv
////////////////////////////////////////////////////////////
// fpu side unit top
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpu_unit_top #(
  parameter int NUM_BUS = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,
  input  fpu_pkg::fpu_op_e     op,
  input  fpu_pkg::data_t       a_reg,
  input  fpu_pkg::data_t       b_reg,
  input  logic [NUM_BUS-1:0]   fwd_now_a,
  input  logic [NUM_BUS-1:0]   fwd_old_a,
  input  logic [NUM_BUS-1:0]   fwd_now_b,
  input  logic [NUM_BUS-1:0]   fwd_old_b,
  input  fpu_pkg::result_t     buses [NUM_BUS],
  input  fpu_pkg::cmp_flags_t  flags_in,
  input  logic [1:0]           exc_enable,
  output logic                 res_valid,
  output fpu_pkg::result_t     res,
  output fpu_pkg::cmp_flags_t  flags_out,
  output logic                 exc_valid,
  output fpu_pkg::exc_code_e   exc_code
);
  import fpu_pkg::*;

  data_t      a_fwd;
  data_t      b_fwd;
  cmp_flags_t cmp_flags;
  data_t      cmp_mask;
  logic [1:0] raise;

  exec_if ex_if ();

  operand_forward #(.NUM_BUS(NUM_BUS)) i_fwd_a (
    .clk(clk), .rst(rst), .reg_val(a_reg),
    .fwd_now(fwd_now_a), .fwd_old(fwd_old_a),
    .buses(buses), .operand(a_fwd)
  );

  operand_forward #(.NUM_BUS(NUM_BUS)) i_fwd_b (
    .clk(clk), .rst(rst), .reg_val(b_reg),
    .fwd_now(fwd_now_b), .fwd_old(fwd_old_b),
    .buses(buses), .operand(b_fwd)
  );

  fpu_issue i_issue (
    .clk(clk), .rst(rst), .en(en), .op(op),
    .a(a_fwd), .b(b_fwd), .issue(ex_if.issue)
  );

  fpu_compare i_compare (
    .issue(ex_if.exec), .flags(cmp_flags), .mask(cmp_mask), .raise(raise)
  );

  fpu_result i_result (
    .clk(clk), .rst(rst), .issue(ex_if.exec),
    .cmp_flags(cmp_flags), .cmp_mask(cmp_mask), .flags_in(flags_in),
    .res_valid(res_valid), .res(res), .flags_out(flags_out)
  );

  fpu_except i_except (
    .clk(clk), .rst(rst), .raise(raise), .exc_enable(exc_enable),
    .exc_valid(exc_valid), .exc_code(exc_code)
  );

endmodule

//--- verification/tb_fpu_unit.sv
////////////////////////////////////////////////////////////
// fpu side unit testbench
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_fpu_unit;
  import fpu_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int BURST = 40;
  // reset, permute, forward, scalar, packed, exceptions, burst, then slack
  localparam int RUN_CYCLES = 8 + 9 + 10 + 16 + 8 + 24 + (BURST + 2) + 50;

  localparam data_t NAN_LO = 64'h0000_0000_7fc0_0000;
  localparam data_t ONE_LO = 64'h0000_0000_3f80_0000;
  localparam data_t DEN_LO = 64'h0000_0000_0000_0001;

  logic       clk = 1'b0;
  logic       rst;
  logic       en;
  fpu_op_e    op;
  data_t      a_reg;
  data_t      b_reg;
  logic [3:0] fwd_now_a;
  logic [3:0] fwd_old_a;
  logic [3:0] fwd_now_b;
  logic [3:0] fwd_old_b;
  result_t    buses [4];
  cmp_flags_t flags_in;
  logic [1:0] exc_enable;
  logic       res_valid;
  result_t    res;
  cmp_flags_t flags_out;
  logic       exc_valid;
  exc_code_e  exc_code;
  integer     seed;

  fpu_unit_top #(.NUM_BUS(4)) i_fpu_unit_top (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", RUN_CYCLES);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input string name, input logic [RESULT_W-1:0] exp,
                       input logic [RESULT_W-1:0] act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic result_t add_parity(input data_t d);
    return {^d, d};
  endfunction

  // expected lane arrangement of the permute opcodes
  function automatic data_t permute_model(input fpu_op_e op_i, input data_t a, input data_t b);
    case (op_i)
      OP_COPY_A: return a;
      OP_COPY_B: return b;
      OP_SWAP:   return {a[31:0], a[63:32]};
      default:   return {a[31:0], a[31:0]};
    endcase
  endfunction

  // one op in, returns in the cycle its result shows
  task automatic issue_and_wait(input fpu_op_e op_i, input data_t a, input data_t b);
    en = 1'b1;
    op = op_i;
    a_reg = a;
    b_reg = b;
    next_cycle();
    en = 1'b0;
    op = OP_NOP;
    check("res_valid early", 65'(1'b0), 65'(res_valid));
    next_cycle();
    check("res_valid", 65'(op_i != OP_NOP), 65'(res_valid));
  endtask

  task automatic compare_pair(input fpu_op_e op_i, input logic [31:0] x,
                              input logic [31:0] y, input logic [3:0] flags_exp);
    // upper lanes hold values a scalar compare must ignore
    issue_and_wait(op_i, {32'h4040_0000, x}, {32'h7fc0_0000, y});
    check("flags_out", 65'(flags_exp), 65'(flags_out));
    check("res scalar", 65'd0, res);
  endtask

  task automatic report_case(input fpu_op_e op_i, input data_t a, input data_t b,
                             input logic [1:0] enable, input exc_code_e code_exp);
    exc_enable = enable;
    issue_and_wait(op_i, a, b);
    check("exc_valid early", 65'(1'b0), 65'(exc_valid));
    next_cycle();
    check("exc_valid", 65'(code_exp != EXC_NONE), 65'(exc_valid));
    check("exc_code", 65'(code_exp), 65'(exc_code));
  endtask

  task automatic permute_ops();
    data_t   a;
    data_t   b;
    fpu_op_e op_k;
    for (int k = 1; k <= 4; k++) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      op_k = fpu_op_e'(3'(k));
      issue_and_wait(op_k, a, b);
      check("res permute", add_parity(permute_model(op_k, a, b)), res);
    end
    next_cycle();
    check("res_valid late", 65'(1'b0), 65'(res_valid));
  endtask

  task automatic forward_paths();
    data_t x;
    data_t y;
    data_t r;
    x = {$random(seed), $random(seed)};
    y = ~x;
    r = {$random(seed), $random(seed)};
    // live select takes the bus value of the issue cycle
    buses[2] = add_parity(x);
    next_cycle();
    buses[2] = add_parity(y);
    fwd_now_a = 4'b0100;
    issue_and_wait(OP_COPY_A, r, r);
    check("res fwd now", add_parity(y), res);
    fwd_now_a = 4'b0000;
    // old select takes the value one cycle earlier
    buses[1] = add_parity(x);
    next_cycle();
    buses[1] = add_parity(y);
    fwd_old_b = 4'b0010;
    issue_and_wait(OP_COPY_B, r, r);
    check("res fwd old", add_parity(x), res);
    fwd_old_b = 4'b0000;
    issue_and_wait(OP_COPY_A, r, ~r);
    check("res fwd none", add_parity(r), res);
  endtask

  task automatic scalar_compare();
    flags_in = 4'b1111;
    compare_pair(OP_CMP_S, 32'h3f80_0000, 32'h4000_0000, 4'b0100);
    compare_pair(OP_CMP_S, 32'h4000_0000, 32'h3f80_0000, 4'b0010);
    compare_pair(OP_CMP_S, 32'hbf80_0000, 32'h3f80_0000, 4'b0100);
    compare_pair(OP_CMP_S, 32'hc000_0000, 32'hbf80_0000, 4'b0100);
    compare_pair(OP_CMP_S, 32'h3fc0_0000, 32'h3fc0_0000, 4'b1000);
    // +0 against -0
    compare_pair(OP_CMP_S, 32'h0000_0000, 32'h8000_0000, 4'b1000);
    compare_pair(OP_CMPU_S, 32'h3f80_0000, 32'h7fc0_0000, 4'b0001);
    compare_pair(OP_CMP_S, 32'h7fc0_0000, 32'h3f80_0000, 4'b0001);
  endtask

  task automatic packed_and_passthrough();
    flags_in = 4'b1010;
    // hi lane 1.0 < 2.0, lo lane 3.0 < 1.0 fails
    issue_and_wait(OP_PCMP_LT, 64'h3f80_0000_4040_0000, 64'h4000_0000_3f80_0000);
    check("res pcmp", add_parity(64'hffff_ffff_0000_0000), res);
    check("flags_out pcmp", 65'(4'b1010), 65'(flags_out));
    // hi lane -1.0 < -3.0 fails, lo lane 2.0 < 2.5
    issue_and_wait(OP_PCMP_LT, 64'hbf80_0000_4000_0000, 64'hc040_0000_4020_0000);
    check("res pcmp", add_parity(64'h0000_0000_ffff_ffff), res);
    flags_in = 4'b0101;
    issue_and_wait(OP_SWAP, 64'h1234_5678_9abc_def0, '0);
    check("flags_out pass", 65'(4'b0101), 65'(flags_out));
    flags_in = 4'b0011;
    issue_and_wait(OP_COPY_B, '0, 64'h0f0f_0f0f_f0f0_f0f0);
    check("flags_out pass", 65'(4'b0011), 65'(flags_out));
  endtask

  task automatic exception_report();
    report_case(OP_CMP_S, NAN_LO, ONE_LO, 2'b01, EXC_INVALID);
    report_case(OP_CMPU_S, NAN_LO, ONE_LO, 2'b11, EXC_NONE);
    report_case(OP_CMP_S, DEN_LO, ONE_LO, 2'b00, EXC_NONE);
    report_case(OP_CMP_S, DEN_LO, ONE_LO, 2'b01, EXC_NONE);
    report_case(OP_CMP_S, DEN_LO, ONE_LO, 2'b10, EXC_DENORMAL);
    report_case(OP_CMP_S, NAN_LO, DEN_LO, 2'b11, EXC_INVALID);
    report_case(OP_PCMP_LT, 64'h0000_0001_3f80_0000, 64'h3f80_0000_4000_0000,
                2'b10, EXC_DENORMAL);
    report_case(OP_PCMP_LT, 64'h7fc0_0000_0000_0001, ONE_LO, 2'b11, EXC_INVALID);
  endtask

  task automatic back_to_back();
    logic [31:0] r;
    logic        exp_valid [BURST];
    result_t     exp_res [BURST];
    data_t       a;
    data_t       b;
    for (int c = 0; c < BURST + 2; c++) begin
      // outputs now belong to the op issued two cycles back
      if (c >= 2) begin
        check("res_valid burst", 65'(exp_valid[c-2]), 65'(res_valid));
        if (exp_valid[c-2]) begin
          check("res burst", exp_res[c-2], res);
        end
      end
      if (c < BURST) begin
        r = $random(seed);
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        op = fpu_op_e'(3'(r[1:0]) + 3'd1);
        exp_res[c] = add_parity(permute_model(op, a, b));
        // roughly one in eight is a nop
        exp_valid[c] = (r[4:2] != 3'd0);
        if (!exp_valid[c]) begin
          op = OP_NOP;
        end
        en = 1'b1;
        a_reg = a;
        b_reg = b;
      end else begin
        en = 1'b0;
        op = OP_NOP;
      end
      next_cycle();
    end
  endtask

  initial begin
    seed = 13;
    rst = 1'b1;
    en = 1'b0;
    op = OP_NOP;
    a_reg = '0;
    b_reg = '0;
    fwd_now_a = '0;
    fwd_old_a = '0;
    fwd_now_b = '0;
    fwd_old_b = '0;
    flags_in = '0;
    exc_enable = 2'b00;
    for (int i = 0; i < 4; i++) begin
      buses[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check("res_valid reset", 65'(1'b0), 65'(res_valid));
    check("flags_out reset", 65'd0, 65'(flags_out));
    check("exc_valid reset", 65'(1'b0), 65'(exc_valid));
    check("exc_code reset", 65'(EXC_NONE), 65'(exc_code));
    permute_ops();
    forward_paths();
    scalar_compare();
    packed_and_passthrough();
    exception_report();
    back_to_back();
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- flist.f
rtl/fpu_pkg.sv
rtl/exec_if.sv
rtl/operand_forward.sv
rtl/fpu_issue.sv
rtl/fpu_compare.sv
rtl/fpu_result.sv
rtl/fpu_except.sv
rtl/fpu_unit_top.sv
verification/tb_fpu_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fpu side unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_fpu_unit -f flist.f > sim.log 2>&1 &&
  ./obj_dir/Vtb_fpu_unit >> sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && echo "simulation failed" && exit 1
grep -q ">>> PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0
